//--- rtl/lsu_addr_decode.sv
/* D-stage address generation and fault check. Fully combinational, not gated by valid.
   Accesses that span two regions are faulted, never split. */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_addr_decode import lsu_pkg::*; (
   input  logic [`LSU_ADDR_W-1:0]   rs1_d,              // Base register
   input  logic [`LSU_OFFSET_W-1:0] offset_d,           // Signed immediate
   input  lsu_op_e                  op_d,
   output logic [`LSU_ADDR_W-1:0]   lsu_addr_d,         // First byte
   output logic [`LSU_ADDR_W-1:0]   end_addr_d,         // Last byte
   output lsu_region_e              region_d,
   output logic                     access_fault_d,
   output logic                     misaligned_fault_d,
   output lsu_mscause_e             mscause_d
);

   logic [`LSU_ADDR_W-1:0] offset_sext;
   logic [1:0]             size_m1;       // Access size in bytes minus one
   lsu_region_e            end_region;
   logic                   region_cross;
   logic                   pic_size_err;
   logic                   unaligned;

   // Window check by offset from base, works for any size-aligned window
   function automatic lsu_region_e region_of(input logic [`LSU_ADDR_W-1:0] a);
      logic [`LSU_ADDR_W-1:0] dccm_off;
      logic [`LSU_ADDR_W-1:0] pic_off;
      dccm_off = a - `LSU_DCCM_BASE;
      pic_off  = a - `LSU_PIC_BASE;
      if (dccm_off < `LSU_DCCM_SIZE)
         return REG_DCCM;
      else if (pic_off < `LSU_PIC_SIZE)
         return REG_PIC;
      else
         return REG_EXT;
   endfunction

   always_comb begin
      case (op_d)
         LB, LBU, SB : size_m1 = 2'd0;
         LH, LHU, SH : size_m1 = 2'd1;
         default     : size_m1 = 2'd3;
      endcase
   end

   //********************************************************************
   // Start and end address
   //********************************************************************
   assign offset_sext = {{(`LSU_ADDR_W-`LSU_OFFSET_W){offset_d[`LSU_OFFSET_W-1]}}, offset_d};
   assign lsu_addr_d  = rs1_d + offset_sext;
   assign end_addr_d  = lsu_addr_d + {{(`LSU_ADDR_W-2){1'b0}}, size_m1};

   assign region_d   = region_of(lsu_addr_d);      // Start region is the reported one
   assign end_region = region_of(end_addr_d);

   //********************************************************************
   // Faults, highest priority first
   //********************************************************************
   assign region_cross = (region_d != end_region);
   assign pic_size_err = (region_d == REG_PIC) & (size_m1 != 2'd3);
   assign unaligned    = |(lsu_addr_d[1:0] & size_m1) & (region_d != REG_DCCM);

   always_comb begin
      access_fault_d     = 1'b0;
      misaligned_fault_d = 1'b0;
      mscause_d          = CAUSE_NONE;
      if (region_cross) begin
         access_fault_d = 1'b1;
         mscause_d      = CAUSE_REGION_CROSS;
      end else if (pic_size_err) begin
         access_fault_d = 1'b1;
         mscause_d      = CAUSE_PIC_SIZE;
      end else if (unaligned) begin
         misaligned_fault_d = 1'b1;
         mscause_d          = CAUSE_UNALIGNED;
      end
   end

endmodule

//--- rtl/lsu_cfg.svh
/* LSU build-time configuration. Region windows must be size-aligned and must not overlap.
   The mscause codes here are the only source for the package cause enum. */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Datapath widths
`define LSU_ADDR_W      32
`define LSU_OFFSET_W    12
`define LSU_MSCAUSE_W   4

//**********************************************************************
// Memory map
//**********************************************************************
`define LSU_DCCM_BASE   32'hF004_0000
`define LSU_DCCM_SIZE   32'h0001_0000   // 64 KB
`define LSU_PIC_BASE    32'hF00C_0000
`define LSU_PIC_SIZE    32'h0000_8000   // 32 KB

// Exception cause codes reported with a fault
`define LSU_CAUSE_NONE          0
`define LSU_CAUSE_REGION_CROSS  2
`define LSU_CAUSE_PIC_SIZE      3
`define LSU_CAUSE_UNALIGNED     4

`endif

//--- rtl/lsu_ctl.sv
/* LSU control top, D->M->R. One access per cycle, no back-pressure.
   All R-stage outputs follow the D inputs by exactly two clocks. */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_ctl import lsu_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    valid_d,
   input  lsu_op_e                 op_d,
   input  logic [`LSU_ADDR_W-1:0]  rs1_d,
   input  logic [`LSU_OFFSET_W-1:0] offset_d,
   input  logic                    flush_m,
   input  logic                    flush_r,
   input  logic [`LSU_ADDR_W-1:0]  ld_data_r,
   output logic [`LSU_ADDR_W-1:0]  lsu_addr_d,
   output logic [`LSU_ADDR_W-1:0]  lsu_addr_r,
   output logic [`LSU_ADDR_W-1:0]  end_addr_r,
   output lsu_region_e             region_r,
   output logic [`LSU_ADDR_W-1:0]  lsu_result_r,
   output logic                    lsu_commit_r,
   output logic                    exc_valid_r,
   output logic                    exc_type_r,
   output lsu_mscause_e            exc_mscause_r
);

   // D-stage decode results
   logic [`LSU_ADDR_W-1:0] end_addr_d;
   lsu_region_e            region_d;
   logic                   access_fault_d;
   logic                   misaligned_fault_d;
   lsu_mscause_e           mscause_d;

   // R-stage packet fields
   logic                   valid_r;
   lsu_op_e                op_r;
   logic                   access_fault_r;
   logic                   misaligned_fault_r;
   lsu_mscause_e           mscause_r;

   lsu_addr_decode u_decode (
      .rs1_d              (rs1_d),
      .offset_d           (offset_d),
      .op_d               (op_d),
      .lsu_addr_d         (lsu_addr_d),
      .end_addr_d         (end_addr_d),
      .region_d           (region_d),
      .access_fault_d     (access_fault_d),
      .misaligned_fault_d (misaligned_fault_d),
      .mscause_d          (mscause_d)
   );

   lsu_stage_pipe u_pipe (
      .clk                (clk),
      .rst                (rst),
      .flush_m            (flush_m),
      .valid_d            (valid_d),
      .op_d               (op_d),
      .lsu_addr_d         (lsu_addr_d),
      .end_addr_d         (end_addr_d),
      .region_d           (region_d),
      .access_fault_d     (access_fault_d),
      .misaligned_fault_d (misaligned_fault_d),
      .mscause_d          (mscause_d),
      .valid_r            (valid_r),
      .op_r               (op_r),
      .lsu_addr_r         (lsu_addr_r),
      .end_addr_r         (end_addr_r),
      .region_r           (region_r),
      .access_fault_r     (access_fault_r),
      .misaligned_fault_r (misaligned_fault_r),
      .mscause_r          (mscause_r)
   );

   lsu_load_result u_result (
      .valid_r            (valid_r),
      .op_r               (op_r),
      .access_fault_r     (access_fault_r),
      .misaligned_fault_r (misaligned_fault_r),
      .mscause_r          (mscause_r),
      .ld_data_r          (ld_data_r),
      .flush_r            (flush_r),
      .lsu_result_r       (lsu_result_r),
      .lsu_commit_r       (lsu_commit_r),
      .exc_valid_r        (exc_valid_r),
      .exc_type_r         (exc_type_r),
      .exc_mscause_r      (exc_mscause_r)
   );

endmodule

//--- rtl/lsu_load_result.sv
/* R-stage result and status. ld_data_r must already be aligned to bit 0.
   Result is formed from the opcode only; qualify it with lsu_commit_r. */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_load_result import lsu_pkg::*; (
   input  logic                   valid_r,
   input  lsu_op_e                op_r,
   input  logic                   access_fault_r,
   input  logic                   misaligned_fault_r,
   input  lsu_mscause_e           mscause_r,
   input  logic [`LSU_ADDR_W-1:0] ld_data_r,          // Raw load data
   input  logic                   flush_r,
   output logic [`LSU_ADDR_W-1:0] lsu_result_r,       // Extended load value
   output logic                   lsu_commit_r,
   output logic                   exc_valid_r,
   output logic                   exc_type_r,         // 1 access, 0 misaligned
   output lsu_mscause_e           exc_mscause_r
);

   //********************************************************************
   // Load data extension
   //********************************************************************
   always_comb begin
      case (op_r)
         LB      : lsu_result_r = {{(`LSU_ADDR_W-8){ld_data_r[7]}}, ld_data_r[7:0]};
         LBU     : lsu_result_r = {{(`LSU_ADDR_W-8){1'b0}}, ld_data_r[7:0]};
         LH      : lsu_result_r = {{(`LSU_ADDR_W-16){ld_data_r[15]}}, ld_data_r[15:0]};
         LHU     : lsu_result_r = {{(`LSU_ADDR_W-16){1'b0}}, ld_data_r[15:0]};
         LW      : lsu_result_r = ld_data_r;
         default : lsu_result_r = '0;                 // Stores return nothing
      endcase
   end

   // flush_r stops writeback but not the exception report
   assign lsu_commit_r  = valid_r & ~flush_r;
   assign exc_valid_r   = valid_r & (access_fault_r | misaligned_fault_r);
   assign exc_type_r    = access_fault_r;
   assign exc_mscause_r = exc_valid_r ? mscause_r : CAUSE_NONE;

endmodule

//--- rtl/lsu_pkg.sv
/* Shared LSU types. Opcode encoding is local to this block and is not the RISC-V funct3.
   Cause values come from the config header. */
`include "lsu_cfg.svh"

package lsu_pkg;

   localparam int unsigned MSC_W = `LSU_MSCAUSE_W;

   // Load/store opcodes, stores are SB, SH, SW
   typedef enum logic [2:0] {
      LB  = 3'd0,
      LH  = 3'd1,
      LW  = 3'd2,
      LBU = 3'd3,
      LHU = 3'd4,
      SB  = 3'd5,
      SH  = 3'd6,
      SW  = 3'd7
   } lsu_op_e;

   // Address space an access falls into
   typedef enum logic [1:0] {
      REG_DCCM = 2'd0,
      REG_PIC  = 2'd1,
      REG_EXT  = 2'd2
   } lsu_region_e;

   typedef enum logic [MSC_W-1:0] {
      CAUSE_NONE         = MSC_W'(`LSU_CAUSE_NONE),
      CAUSE_REGION_CROSS = MSC_W'(`LSU_CAUSE_REGION_CROSS),   // Start/end in different regions
      CAUSE_PIC_SIZE     = MSC_W'(`LSU_CAUSE_PIC_SIZE),       // PIC takes words only
      CAUSE_UNALIGNED    = MSC_W'(`LSU_CAUSE_UNALIGNED)       // Misaligned outside DCCM
   } lsu_mscause_e;

endpackage

//--- rtl/lsu_stage_pipe.sv
/* D->M->R packet registers. No stall input, the pipe advances every clock.
   Only the valid bits reset; payload is meaningless while its valid is low. */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_stage_pipe import lsu_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   flush_m,            // Kills D and M
   input  logic                   valid_d,
   input  lsu_op_e                op_d,
   input  logic [`LSU_ADDR_W-1:0] lsu_addr_d,
   input  logic [`LSU_ADDR_W-1:0] end_addr_d,
   input  lsu_region_e            region_d,
   input  logic                   access_fault_d,
   input  logic                   misaligned_fault_d,
   input  lsu_mscause_e           mscause_d,
   output logic                   valid_r,
   output lsu_op_e                op_r,
   output logic [`LSU_ADDR_W-1:0] lsu_addr_r,
   output logic [`LSU_ADDR_W-1:0] end_addr_r,
   output lsu_region_e            region_r,
   output logic                   access_fault_r,
   output logic                   misaligned_fault_r,
   output lsu_mscause_e           mscause_r
);

   // M-stage packet
   logic                   valid_m;
   lsu_op_e                op_m;
   logic [`LSU_ADDR_W-1:0] lsu_addr_m;
   logic [`LSU_ADDR_W-1:0] end_addr_m;
   lsu_region_e            region_m;
   logic                   access_fault_m;
   logic                   misaligned_fault_m;
   lsu_mscause_e           mscause_m;

   //********************************************************************
   // Valid bits
   //********************************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_m <= 1'b0;
         valid_r <= 1'b0;
      end else begin
         valid_m <= valid_d & ~flush_m;
         valid_r <= valid_m & ~flush_m;   // Flush also drops the M packet
      end
   end

   // Payload moves every cycle
   always_ff @(posedge clk) begin
      op_m               <= op_d;
      lsu_addr_m         <= lsu_addr_d;
      end_addr_m         <= end_addr_d;
      region_m           <= region_d;
      access_fault_m     <= access_fault_d;
      misaligned_fault_m <= misaligned_fault_d;
      mscause_m          <= mscause_d;
   end

   always_ff @(posedge clk) begin
      op_r               <= op_m;
      lsu_addr_r         <= lsu_addr_m;
      end_addr_r         <= end_addr_m;
      region_r           <= region_m;
      access_fault_r     <= access_fault_m;
      misaligned_fault_r <= misaligned_fault_m;
      mscause_r          <= mscause_m;
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the lsu_ctl testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module lsu_ctl_tb \
   -o sim_lsu_ctl > build.log 2>&1 \
   && ./obj_dir/sim_lsu_ctl > sim.log 2>&1 \
   || echo "Build or simulation stopped with an error, see build.log and sim.log"

grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" && exit 0 \
   || { echo "Simulation failed"; exit 1; }

//--- tests/lsu_checker.sv
/* Scoreboard for lsu_ctl. Expected values are presented with each D-stage access
   and carried two edges to R. Outputs are sampled on the rising edge. */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_checker import lsu_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   valid_d,
   input  logic                   flush_m,
   input  logic                   flush_r,
   input  logic                   report_now,    // Prints the summary line
   input  logic [`LSU_ADDR_W-1:0] exp_addr,
   input  logic [`LSU_ADDR_W-1:0] exp_end,
   input  lsu_region_e            exp_region,
   input  logic [`LSU_ADDR_W-1:0] exp_result,
   input  logic                   exp_acc,
   input  logic                   exp_mis,
   input  lsu_mscause_e           exp_cause,
   input  logic [`LSU_ADDR_W-1:0] lsu_addr_d,
   input  logic [`LSU_ADDR_W-1:0] lsu_addr_r,
   input  logic [`LSU_ADDR_W-1:0] end_addr_r,
   input  lsu_region_e            region_r,
   input  logic [`LSU_ADDR_W-1:0] lsu_result_r,
   input  logic                   lsu_commit_r,
   input  logic                   exc_valid_r,
   input  logic                   exc_type_r,
   input  lsu_mscause_e           exc_mscause_r,
   output int                     error_count
);

   int errors = 0;
   int checks = 0;

   // Expected packet in M and R
   logic                   m_v, r_v;
   logic [`LSU_ADDR_W-1:0] m_addr, r_addr, m_end, r_end, m_res, r_res;
   lsu_region_e            m_reg, r_reg;
   logic                   m_acc, r_acc, m_mis, r_mis;
   lsu_mscause_e           m_cause, r_cause;
   logic                   r_exc;

   assign error_count = errors;
   assign r_exc       = r_v & (r_acc | r_mis);

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   //*********************************************************************
   // Compare, then advance the expected pipe
   //*********************************************************************
   always @(posedge clk) begin
      if (rst) begin
         m_v <= 1'b0;
         r_v <= 1'b0;
      end else begin
         if (valid_d)
            check("lsu_addr_d", exp_addr, lsu_addr_d);   // Same-cycle address
         check("lsu_commit_r", {31'd0, r_v & ~flush_r}, {31'd0, lsu_commit_r});
         check("exc_valid_r", {31'd0, r_exc}, {31'd0, exc_valid_r});
         check("exc_mscause_r", r_exc ? r_cause : CAUSE_NONE, exc_mscause_r);
         if (r_v) begin
            check("lsu_addr_r", r_addr, lsu_addr_r);
            check("end_addr_r", r_end, end_addr_r);
            check("region_r", r_reg, region_r);
            check("lsu_result_r", r_res, lsu_result_r);
            if (r_exc)
               check("exc_type_r", {31'd0, r_acc}, {31'd0, exc_type_r});
         end
         m_v <= valid_d & ~flush_m;
         r_v <= m_v & ~flush_m;   // flush_m also drops M
      end
      m_addr  <= exp_addr;
      m_end   <= exp_end;
      m_reg   <= exp_region;
      m_res   <= exp_result;
      m_acc   <= exp_acc;
      m_mis   <= exp_mis;
      m_cause <= exp_cause;
      r_addr  <= m_addr;
      r_end   <= m_end;
      r_reg   <= m_reg;
      r_res   <= m_res;
      r_acc   <= m_acc;
      r_mis   <= m_mis;
      r_cause <= m_cause;
   end

   always @(posedge report_now)
      $display("Checker summary: %0d errors in %0d checks", errors, checks);

endmodule

//--- tests/lsu_clk_gen.sv
/* Testbench clock and reset. 20 ns period, reset held for two rising edges
   and released on a falling edge. */
`timescale 1ns/1ns

module lsu_clk_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;   // Released away from the sampling edge
   end

endmodule

//--- tests/lsu_ctl_assertions.sv
/* Protocol properties of the LSU R stage, bound into every lsu_ctl instance.
   Checked on the rising edge only. */
`timescale 1ns/1ns

module lsu_ctl_assertions import lsu_pkg::*; (
   input logic         clk,
   input logic         rst,
   input logic         flush_m,
   input logic         flush_r,
   input logic         lsu_commit_r,
   input logic         exc_valid_r,
   input lsu_mscause_e exc_mscause_r
);

   // Commit only for a packet that no flush has touched on its way to R
   commit_not_flushed: assert property (
      @(posedge clk) disable iff (rst)
         lsu_commit_r |-> (!flush_r && !$past(flush_m) && !$past(flush_m, 2))
   ) else $error("lsu_commit_r high for a flushed packet");

   // A reported exception always carries a cause
   exc_has_cause: assert property (
      @(posedge clk) disable iff (rst) exc_valid_r |-> (exc_mscause_r != CAUSE_NONE)
   ) else $error("exc_valid_r high with cause none");

   quiet_after_reset: assert property (
      @(posedge clk) $fell(rst) |-> (!lsu_commit_r && !exc_valid_r)
   ) else $error("commit or exception right after reset");

endmodule

bind lsu_ctl lsu_ctl_assertions u_assertions (.*);

//--- tests/lsu_ctl_tb.sv
/* Top testbench for lsu_ctl. Directed cases first, then seeded random traffic.
   ld_data_r follows the access that sits in R, taken from a 3-deep history. */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_ctl_tb import lsu_pkg::*;;

   localparam int NUM_DIRECTED = 40;    // Upper bound of directed cycles
   localparam int NUM_RANDOM   = 200;
   localparam int WATCHDOG_NS  = (NUM_DIRECTED + NUM_RANDOM + 10) * 20;

   logic clk, rst;
   logic valid_d, flush_m, flush_r, report_now;
   lsu_op_e op_d;
   logic [31:0] rs1_d, ld_data_r;
   logic [11:0] offset_d;
   logic [31:0] lsu_addr_d, lsu_addr_r, end_addr_r, lsu_result_r;
   lsu_region_e region_r;
   logic lsu_commit_r, exc_valid_r, exc_type_r;
   lsu_mscause_e exc_mscause_r;

   // Expected values of the access in D
   logic [31:0] exp_addr, exp_end, exp_result;
   lsu_region_e exp_region;
   logic exp_acc, exp_mis;
   lsu_mscause_e exp_cause;
   int error_count;

   integer seed;
   logic [31:0] data_hist[$];

   lsu_clk_gen u_clk (.clk(clk), .rst(rst));

   lsu_ctl UUT (.*);

   lsu_checker u_checker (.*);

   function automatic lsu_region_e region_at(input logic [31:0] a);
      if (a >= `LSU_DCCM_BASE && a <= `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 32'd1)
         return REG_DCCM;
      if (a >= `LSU_PIC_BASE && a <= `LSU_PIC_BASE + `LSU_PIC_SIZE - 32'd1)
         return REG_PIC;
      return REG_EXT;
   endfunction

   //*********************************************************************
   // Reference model of one access
   //*********************************************************************
   function automatic void lsu_ref(input lsu_op_e op, input logic [31:0] rs1,
                                   input logic [11:0] off, input logic [31:0] data,
                                   output logic [31:0] addr, output logic [31:0] end_a,
                                   output lsu_region_e reg_s, output logic acc,
                                   output logic mis, output lsu_mscause_e cause,
                                   output logic [31:0] res);
      logic [31:0] size;
      lsu_region_e reg_e;
      case (op)
         LB, LBU, SB : size = 32'd1;
         LH, LHU, SH : size = 32'd2;
         default     : size = 32'd4;
      endcase
      addr  = rs1 + {{20{off[11]}}, off};
      end_a = addr + size - 32'd1;
      reg_s = region_at(addr);
      reg_e = region_at(end_a);
      acc   = 1'b0;
      mis   = 1'b0;
      cause = CAUSE_NONE;
      if (reg_s != reg_e) begin
         acc   = 1'b1;
         cause = CAUSE_REGION_CROSS;
      end else if (reg_s == REG_PIC && size != 32'd4) begin
         acc   = 1'b1;
         cause = CAUSE_PIC_SIZE;
      end else if ((addr % size) != 32'd0 && reg_s != REG_DCCM) begin
         mis   = 1'b1;
         cause = CAUSE_UNALIGNED;
      end
      case (op)
         LB      : res = {{24{data[7]}}, data[7:0]};
         LBU     : res = {24'd0, data[7:0]};
         LH      : res = {{16{data[15]}}, data[15:0]};
         LHU     : res = {16'd0, data[15:0]};
         LW      : res = data;
         default : res = 32'd0;   // Stores
      endcase
   endfunction

   // One cycle of stimulus, applied on the falling edge
   task automatic issue(input logic v, input lsu_op_e op, input logic [31:0] rs1,
                        input logic [11:0] off, input logic [31:0] data,
                        input logic fm, input logic fr);
      logic [31:0] a, e, r;
      lsu_region_e rg;
      logic ac, mi;
      lsu_mscause_e c;
      @(negedge clk);
      lsu_ref(op, rs1, off, data, a, e, rg, ac, mi, c, r);
      valid_d    = v;
      op_d       = op;
      rs1_d      = rs1;
      offset_d   = off;
      flush_m    = fm;
      flush_r    = fr;   // Applies to the access now in R
      exp_addr   = a;
      exp_end    = e;
      exp_region = rg;
      exp_acc    = ac;
      exp_mis    = mi;
      exp_cause  = c;
      exp_result = r;
      data_hist.push_back(data);
      if (data_hist.size() > 3)
         void'(data_hist.pop_front());
      ld_data_r = (data_hist.size() == 3) ? data_hist[0] : 32'd0;
   endtask

   task automatic idle(input logic fr);
      issue(1'b0, LW, 32'd0, 12'd0, 32'd0, 1'b0, fr);
   endtask

   task automatic random_access();
      logic [31:0] base, pick, tmp;
      logic v, fm, fr;
      pick = {$random(seed)} % 5;
      case (pick)
         32'd0   : base = `LSU_DCCM_BASE;
         32'd1   : base = `LSU_DCCM_BASE + `LSU_DCCM_SIZE;
         32'd2   : base = `LSU_PIC_BASE;
         32'd3   : base = `LSU_PIC_BASE + `LSU_PIC_SIZE;
         default : base = $random(seed);
      endcase
      base = base + ({$random(seed)} % 64) - 32'd32;   // Hover around the edges
      tmp  = $random(seed);
      v    = ({$random(seed)} % 8) != 0;
      fm   = ({$random(seed)} % 10) == 0;
      fr   = ({$random(seed)} % 10) == 0;
      issue(v, lsu_op_e'(tmp[14:12]), base, tmp[11:0], $random(seed), fm, fr);
   endtask

   //*********************************************************************
   // Stimulus
   //*********************************************************************
   initial begin
      seed       = 68584;
      valid_d    = 1'b1;   // Access held during reset must never reach R
      op_d       = LW;
      rs1_d      = 32'd0;
      offset_d   = 12'd0;
      flush_m    = 1'b0;
      flush_r    = 1'b0;
      ld_data_r  = 32'd0;
      report_now = 1'b0;
      exp_addr   = 32'd0;
      exp_end    = 32'd0;
      exp_result = 32'd0;
      exp_region = REG_EXT;
      exp_acc    = 1'b0;
      exp_mis    = 1'b0;
      exp_cause  = CAUSE_NONE;
      wait (!rst);
      valid_d = 1'b0;

      // Loads and stores in DCCM back to back
      issue(1'b1, LW,  `LSU_DCCM_BASE, 12'h000, 32'h1234_5678, 1'b0, 1'b0);
      issue(1'b1, LB,  `LSU_DCCM_BASE, 12'h004, 32'hAAAA_AA80, 1'b0, 1'b0);
      issue(1'b1, LB,  `LSU_DCCM_BASE, 12'h005, 32'h5555_557F, 1'b0, 1'b0);
      issue(1'b1, LBU, `LSU_DCCM_BASE, 12'h006, 32'hFFFF_FF80, 1'b0, 1'b0);
      issue(1'b1, LBU, `LSU_DCCM_BASE, 12'h007, 32'h0000_007F, 1'b0, 1'b0);
      issue(1'b1, LH,  `LSU_DCCM_BASE, 12'h008, 32'h0000_8001, 1'b0, 1'b0);
      issue(1'b1, LH,  `LSU_DCCM_BASE, 12'h00A, 32'hFFFF_7001, 1'b0, 1'b0);
      issue(1'b1, LHU, `LSU_DCCM_BASE, 12'h00C, 32'hFFFF_8001, 1'b0, 1'b0);
      issue(1'b1, LHU, `LSU_DCCM_BASE, 12'h00E, 32'hFFFF_7FFF, 1'b0, 1'b0);
      issue(1'b1, SW,  `LSU_DCCM_BASE, 12'h010, 32'hDEAD_BEEF, 1'b0, 1'b0);
      issue(1'b1, LW,  `LSU_DCCM_BASE + 32'h20, 12'hFF0, 32'h0BAD_F00D, 1'b0, 1'b0);

      // Window edges and faults
      issue(1'b1, LB, `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 32'd1, 12'h0, 32'h11, 1'b0, 1'b0);
      issue(1'b1, LW, `LSU_PIC_BASE + `LSU_PIC_SIZE - 32'd4, 12'h0, 32'h22, 1'b0, 1'b0);
      issue(1'b1, LB, `LSU_PIC_BASE + `LSU_PIC_SIZE - 32'd1, 12'h0, 32'h33, 1'b0, 1'b0);
      issue(1'b1, LW, 32'h0000_1000, 12'h0, 32'h44, 1'b0, 1'b0);
      issue(1'b1, LW, `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 32'd2, 12'h0, 32'h55, 1'b0, 1'b0);
      issue(1'b1, LB, `LSU_PIC_BASE, 12'h0, 32'h66, 1'b0, 1'b0);
      issue(1'b1, LH, 32'h0000_1001, 12'h0, 32'h77, 1'b0, 1'b0);
      issue(1'b1, LW, `LSU_DCCM_BASE + 32'd1, 12'h0, 32'h88, 1'b0, 1'b0);

      // flush_m kills the access in D and the one in M
      issue(1'b1, LW, `LSU_DCCM_BASE, 12'h040, 32'h99, 1'b0, 1'b0);
      issue(1'b1, LW, `LSU_DCCM_BASE, 12'h044, 32'hAA, 1'b1, 1'b0);
      idle(1'b0);
      idle(1'b0);

      // flush_r blocks the commit but the fault still reports
      issue(1'b1, LB, `LSU_PIC_BASE, 12'h001, 32'hBB, 1'b0, 1'b0);
      idle(1'b0);
      idle(1'b1);
      idle(1'b0);

      repeat (NUM_RANDOM) random_access();
      repeat (3) idle(1'b0);

      @(negedge clk);
      report_now = 1'b1;
      #1;
      if (error_count == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_addr_decode.sv
rtl/lsu_stage_pipe.sv
rtl/lsu_load_result.sv
rtl/lsu_ctl.sv
tests/lsu_clk_gen.sv
tests/lsu_checker.sv
tests/lsu_ctl_assertions.sv
tests/lsu_ctl_tb.sv
